// File: verilog.f
common/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_regfile.sv
execute/rv_alu.sv
execute/rv_execute.sv
rtl/rv_trap_csr.sv
rtl/rv_core.sv
sim/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_rv_core -o tb_rv_core

./obj_dir/tb_rv_core > sim.log 2>&1 || true
cat sim.log

# pass only if the testbench printed its pass line
grep -q "^Simulation finished: PASS$" sim.log
echo "run_sim: passed"

// File: sim/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core
   import rv_pkg::*;
;

   localparam pc_t   RESET_PC        = 40'h80000000;
   localparam xlen_t MARKER          = 64'h5a5;   // only the skipped stores carry it
   localparam int    N_STORES        = 14;
   localparam int    PRE_IRQ_STORES  = 12;        // stores before the spin loop
   localparam int    PROG_WORDS      = 64;
   localparam int    WATCHDOG_CYCLES = PROG_WORDS * 60 + 160;   // ~60 cycles per word, slow bus

   logic       clk;
   logic       reset;
   inst_t      instruction_i;
   pc_t        pc_o;
   logic       heartbeat_o;
   logic [3:0] interrupt_vector_i;
   logic       interrupt_ack_o;
   bus_req_t   bus_o;
   logic       bus_read_done_i;
   logic       bus_write_done_i;
   xlen_t      bus_read_data_i;

   inst_t   prog [PROG_WORDS];
   pc_t     prog_off;
   logic [7:0] dmem [512];
   paddr_t  exp_addr [16];
   xlen_t   exp_data [16];
   funct3_t exp_type [16];
   int      st_cnt, ack_cnt, err_cnt;
   logic    busy, is_rd;
   logic [1:0]  wait_cnt;
   logic [31:0] rng;

   rv_core #(.RESET_PC(RESET_PC)) i_rv_core (
      .clk                (clk),
      .reset              (reset),
      .instruction_i      (instruction_i),
      .pc_o               (pc_o),
      .heartbeat_o        (heartbeat_o),
      .interrupt_vector_i (interrupt_vector_i),
      .interrupt_ack_o    (interrupt_ack_o),
      .bus_o              (bus_o),
      .bus_read_done_i    (bus_read_done_i),
      .bus_write_done_i   (bus_write_done_i),
      .bus_read_data_i    (bus_read_data_i)
   );

   always #4 clk = ~clk;   // 8 ns period

   // instruction memory answers in the same cycle
   assign prog_off      = pc_o - RESET_PC;
   assign instruction_i = (prog_off < 40'd256) ? prog[prog_off[7:2]] : INST_NOP;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // instruction encoders
   function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, funct3_t f3,
                                   reg_idx_t rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic inst_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
   endfunction

   function automatic inst_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3,
                                   reg_idx_t rd, logic [6:0] op);
      return {f7, rs2, rs1, f3, rd, op};
   endfunction

   function automatic inst_t enc_b(logic [12:0] off, reg_idx_t rs1, reg_idx_t rs2, funct3_t f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
   endfunction

   function automatic inst_t enc_j(logic [20:0] off, reg_idx_t rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
   endfunction

   task automatic load_program();
      for (int i = 0; i < PROG_WORDS; i++) prog[i] = INST_NOP;
      prog[0]  = enc_u(20'h12345, 1, 7'h37);              // lui x1
      prog[1]  = enc_i(12'h678, 1, 0, 1, 7'h13);
      prog[2]  = enc_s(12'h100, 1, 0, 3);
      prog[3]  = enc_i(12'hffb, 0, 0, 2, 7'h13);          // x2 = -5
      prog[4]  = enc_r(7'h20, 1, 2, 0, 3, 7'h33);         // sub x3, x2, x1
      prog[5]  = enc_s(12'h108, 3, 0, 3);
      prog[6]  = enc_i(12'h404, 3, 5, 4, 7'h13);          // srai x4, x3, 4
      prog[7]  = enc_s(12'h110, 4, 0, 3);
      prog[8]  = enc_u(20'h7ffff, 5, 7'h37);
      prog[9]  = enc_r(7'h00, 5, 5, 0, 6, 7'h3b);         // addw overflows
      prog[10] = enc_s(12'h118, 6, 0, 3);
      prog[11] = enc_i(12'h080, 0, 0, 8, 7'h13);
      prog[12] = enc_s(12'h120, 8, 0, 0);                 // sb
      prog[13] = enc_u(20'h0000a, 9, 7'h37);
      prog[14] = enc_i(12'h876, 9, 0, 9, 7'h13);          // x9 = 0x9876
      prog[15] = enc_s(12'h128, 9, 0, 1);                 // sh
      prog[16] = enc_i(12'h120, 0, 0, 10, 7'h03);         // lb
      prog[17] = enc_i(12'h120, 0, 4, 11, 7'h03);         // lbu
      prog[18] = enc_i(12'h128, 0, 1, 12, 7'h03);         // lh
      prog[19] = enc_i(12'h128, 0, 5, 13, 7'h03);         // lhu
      for (int i = 0; i < 4; i++) prog[20+i] = enc_s(12'h130 + 12'(8*i), 5'(10+i), 0, 3);
      prog[24] = enc_i(MARKER[11:0], 0, 0, 14, 7'h13);
      prog[25] = enc_b(13'd8, 0, 0, 0);                   // beq taken, skips marker
      prog[26] = enc_s(12'h150, 14, 0, 3);
      prog[27] = enc_j(21'd8, 15);                        // jal skips marker
      prog[28] = enc_s(12'h158, 14, 0, 3);
      prog[29] = enc_s(12'h160, 15, 0, 3);                // link value
      prog[30] = enc_u(20'h0, 16, 7'h17);                 // auipc
      prog[31] = enc_i(12'd72, 16, 0, 16, 7'h13);         // handler at word 48
      prog[32] = enc_i(CSR_MTVEC, 16, 1, 17, 7'h73);      // csrrw
      prog[33] = enc_s(12'h168, 17, 0, 3);
      prog[34] = enc_b(13'd0, 7, 0, 0);                   // spin until handler sets x7
      prog[35] = enc_s(12'h178, 7, 0, 3);
      prog[36] = enc_j(21'd0, 0);                         // park
      prog[48] = enc_i(CSR_MCAUSE, 0, 2, 18, 7'h73);      // csrr mcause
      prog[49] = enc_s(12'h170, 18, 0, 3);
      prog[50] = enc_i(12'd1, 0, 0, 7, 7'h13);
      prog[51] = INST_MRET;
   endtask

   task automatic fill_expected();
      xlen_t       x3;
      logic [31:0] w;
      logic [7:0]  b;
      logic [15:0] h;
      x3 = 64'hffff_ffff_ffff_fffb - 64'h1234_5678;
      w  = 32'h7ffff000 + 32'h7ffff000;
      b  = 8'h80;
      h  = 16'h9876;
      for (int i = 0; i < 16; i++) exp_type[i] = 3'd3;
      exp_addr[0]  = 39'h100;
      exp_data[0]  = 64'h1234_5678;
      exp_addr[1]  = 39'h108;
      exp_data[1]  = x3;
      exp_addr[2]  = 39'h110;
      exp_data[2]  = xlen_t'($signed(x3) >>> 4);
      exp_addr[3]  = 39'h118;
      exp_data[3]  = {{32{w[31]}}, w};
      exp_addr[4]  = 39'h120;
      exp_data[4]  = {56'b0, b};
      exp_type[4]  = 3'd0;
      exp_addr[5]  = 39'h128;
      exp_data[5]  = {48'b0, h};
      exp_type[5]  = 3'd1;
      exp_addr[6]  = 39'h130;
      exp_data[6]  = {{56{b[7]}}, b};
      exp_addr[7]  = 39'h138;
      exp_data[7]  = {56'b0, b};
      exp_addr[8]  = 39'h140;
      exp_data[8]  = {{48{h[15]}}, h};
      exp_addr[9]  = 39'h148;
      exp_data[9]  = {48'b0, h};
      exp_addr[10] = 39'h160;
      exp_data[10] = {24'b0, RESET_PC + 40'd112};
      exp_addr[11] = 39'h168;
      exp_data[11] = {24'b0, RESET_PC};   // old mtvec
      exp_addr[12] = 39'h170;
      exp_data[12] = (64'd1 << 63) | 64'd11;
      exp_addr[13] = 39'h178;
      exp_data[13] = 64'd1;
      for (int i = 14; i < 16; i++) begin
         exp_addr[i] = '0;
         exp_data[i] = '0;
      end
   endtask

   // data memory, random 1..4 cycle latency
   always @(posedge clk) begin : data_mem
      logic [31:0] nxt;
      nxt = xorshift(rng);
      bus_read_done_i  <= 1'b0;
      bus_write_done_i <= 1'b0;
      if (!reset) begin
         busy <= 1'b0;
         rng  <= 32'h4d5b1aec;
         for (int i = 0; i < 512; i++) dmem[i] <= 8'(i * 37 + (i >> 8));
      end else if (busy) begin
         if (wait_cnt == 2'd0) begin
            busy <= 1'b0;
            if (is_rd) begin
               bus_read_done_i <= 1'b1;
               for (int k = 0; k < 8; k++)
                  bus_read_data_i[8*k +: 8] <= dmem[bus_o.address[8:0] + 9'(k)];
            end else begin
               bus_write_done_i <= 1'b1;
               for (int k = 0; k < (1 << bus_o.ls_type[1:0]); k++)
                  dmem[bus_o.address[8:0] + 9'(k)] <= bus_o.write_data[8*k +: 8];
            end
         end else begin
            wait_cnt <= wait_cnt - 2'd1;
         end
      end else if (bus_o.read_enable || bus_o.write_enable) begin
         busy     <= 1'b1;
         is_rd    <= bus_o.read_enable;
         rng      <= nxt;
         wait_cnt <= nxt[1:0];
      end
   end

   always @(posedge clk) begin
      if (!reset) begin
         st_cnt  <= 0;
         ack_cnt <= 0;
      end else begin
         if (bus_o.write_enable) st_cnt <= st_cnt + 1;
         if (interrupt_ack_o) ack_cnt <= ack_cnt + 1;
      end
   end

   // from the second reset edge on, once the async reset has settled
   a_reset_state: assert property (@(posedge clk) !reset && $past(!reset) |->
      pc_o == RESET_PC && !bus_o.read_enable && !bus_o.write_enable && !interrupt_ack_o)
      else begin
         err_cnt++;
         $display("FAILED %0t: reset state wrong, pc %h", $time, pc_o);
      end

   a_heartbeat: assert property (@(posedge clk) disable iff (!reset)
      $past(reset) |-> heartbeat_o != $past(heartbeat_o))
      else begin
         err_cnt++;
         $display("FAILED %0t: heartbeat did not toggle", $time);
      end

   a_store: assert property (@(posedge clk) disable iff (!reset)
      bus_o.write_enable |-> st_cnt < N_STORES && bus_o.address == exp_addr[st_cnt] &&
         bus_o.write_data == exp_data[st_cnt] && bus_o.ls_type == exp_type[st_cnt])
      else begin
         err_cnt++;
         $display("FAILED %0t: store %0d got addr %h data %h type %0d, want %h %h %0d", $time,
                  st_cnt, bus_o.address, bus_o.write_data, bus_o.ls_type,
                  exp_addr[st_cnt], exp_data[st_cnt], exp_type[st_cnt]);
      end

   a_no_marker: assert property (@(posedge clk) disable iff (!reset)
      bus_o.write_enable |-> bus_o.write_data != MARKER)
      else begin
         err_cnt++;
         $display("FAILED %0t: skipped marker store reached the bus", $time);
      end

   a_ack_vector: assert property (@(posedge clk) disable iff (!reset)
      interrupt_ack_o |-> pc_o == RESET_PC + 40'd192)   // mtvec = word 48
      else begin
         err_cnt++;
         $display("FAILED %0t: pc %h not at handler on ack", $time, pc_o);
      end

   a_ack_pulse: assert property (@(posedge clk) disable iff (!reset)
      interrupt_ack_o |=> !interrupt_ack_o)
      else begin
         err_cnt++;
         $display("FAILED %0t: interrupt ack longer than one cycle", $time);
      end

   initial begin
      clk                = 1'b0;
      reset              = 1'b0;
      interrupt_vector_i = 4'd0;
      bus_read_done_i    = 1'b0;
      bus_write_done_i   = 1'b0;
      bus_read_data_i    = '0;
      err_cnt            = 0;
      load_program();
      fill_expected();
      repeat (16) @(posedge clk);
      reset <= 1'b1;
      while (st_cnt < PRE_IRQ_STORES) @(posedge clk);
      interrupt_vector_i <= 4'd1;
      while (!interrupt_ack_o) @(posedge clk);
      interrupt_vector_i <= 4'd0;   // dropped before the handler's mret
      while (st_cnt < N_STORES) @(posedge clk);
      repeat (40) @(posedge clk);   // park loop, no stray stores
      if (st_cnt != N_STORES || ack_cnt != 1) begin
         err_cnt++;
         $display("FAILED %0t: %0d stores and %0d acks, want %0d and 1", $time,
                  st_cnt, ack_cnt, N_STORES);
      end
      $display("errors %0d, stores %0d, interrupt acks %0d", err_cnt, st_cnt, ack_cnt);
      if (err_cnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the program did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("errors %0d, stores %0d, interrupt acks %0d", err_cnt, st_cnt, ack_cnt);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: rtl/rv_core.sv
`timescale 1ns/100ps

module rv_core
   import rv_pkg::*;
#(
   parameter pc_t RESET_PC = 40'h80000000
) (
   input  logic       clk,
   input  logic       reset,
   input  inst_t      instruction_i,
   output pc_t        pc_o,
   output logic       heartbeat_o,
   input  logic [3:0] interrupt_vector_i,
   output logic       interrupt_ack_o,
   output bus_req_t   bus_o,
   input  logic       bus_read_done_i,
   input  logic       bus_write_done_i,
   input  xlen_t      bus_read_data_i
);

   inst_t     ir;
   pc_t       ir_pc;
   xlen_t     rs1, rs2;
   rf_write_t rf_wr;
   redirect_t redirect;
   logic      stall;
   csr_req_t  csr_req;
   xlen_t     csr_rdata;
   logic      mret, irq_ok, irq_take;
   pc_t       trap_target;

   assign ir_pc = pc_o - 40'd4;   // fetch runs one word ahead of ir

   rv_fetch #(.RESET_PC(RESET_PC)) i_rv_fetch (
      .clk           (clk),
      .reset         (reset),
      .redirect_i    (redirect),
      .stall_i       (stall),
      .pc_o          (pc_o),
      .ir_o          (ir),
      .instruction_i (instruction_i)
   );

   rv_regfile i_rv_regfile (
      .clk       (clk),
      .reset     (reset),
      .rs1_idx_i (ir[19:15]),
      .rs2_idx_i (ir[24:20]),
      .rs1_o     (rs1),
      .rs2_o     (rs2),
      .wr_i      (rf_wr)
   );

   rv_execute i_rv_execute (
      .clk              (clk),
      .reset            (reset),
      .ir_i             (ir),
      .pc_i             (ir_pc),
      .rs1_i            (rs1),
      .rs2_i            (rs2),
      .rf_wr_o          (rf_wr),
      .redirect_o       (redirect),
      .stall_o          (stall),
      .bus_o            (bus_o),
      .bus_read_done_i  (bus_read_done_i),
      .bus_write_done_i (bus_write_done_i),
      .bus_read_data_i  (bus_read_data_i),
      .csr_o            (csr_req),
      .csr_rdata_i      (csr_rdata),
      .mret_o           (mret),
      .irq_ok_o         (irq_ok),
      .irq_take_i       (irq_take),
      .trap_target_i    (trap_target)
   );

   rv_trap_csr #(.RESET_PC(RESET_PC)) i_rv_trap_csr (
      .clk                (clk),
      .reset              (reset),
      .csr_i              (csr_req),
      .csr_rdata_o        (csr_rdata),
      .mret_i             (mret),
      .ir_pc_i            (ir_pc),
      .interrupt_vector_i (interrupt_vector_i),
      .irq_ok_i           (irq_ok),
      .irq_take_o         (irq_take),
      .trap_target_o      (trap_target),
      .interrupt_ack_o    (interrupt_ack_o)
   );

   // alive indicator, flips every cycle
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         heartbeat_o <= 1'b0;
      end else begin
         heartbeat_o <= ~heartbeat_o;
      end
   end

endmodule

// File: rtl/rv_trap_csr.sv
`timescale 1ns/100ps

module rv_trap_csr
   import rv_pkg::*;
#(
   parameter pc_t RESET_PC = 40'h80000000
) (
   input  logic       clk,
   input  logic       reset,
   input  csr_req_t   csr_i,
   output xlen_t      csr_rdata_o,
   input  logic       mret_i,
   input  pc_t        ir_pc_i,
   input  logic [3:0] interrupt_vector_i,
   input  logic       irq_ok_i,
   output logic       irq_take_o,
   output pc_t        trap_target_o,
   output logic       interrupt_ack_o
);

   xlen_t mstatus, mtvec, mepc, mcause;
   xlen_t csr_new;
   logic  csr_we;

   assign irq_take_o    = irq_ok_i && mstatus[MSTATUS_MIE] && interrupt_vector_i == 4'd1;
   assign trap_target_o = irq_take_o ? mtvec[39:0] : mepc[39:0];   // handler or return

   always_comb begin
      case (csr_i.addr)
         CSR_MSTATUS: csr_rdata_o = mstatus;
         CSR_MTVEC:   csr_rdata_o = mtvec;
         CSR_MEPC:    csr_rdata_o = mepc;
         CSR_MCAUSE:  csr_rdata_o = mcause;
         default:     csr_rdata_o = '0;
      endcase
   end

   always_comb begin
      case (csr_i.op[1:0])
         2'b01:   csr_new = csr_i.wdata;                  // rw
         2'b10:   csr_new = csr_rdata_o | csr_i.wdata;    // set
         default: csr_new = csr_rdata_o & ~csr_i.wdata;   // clear
      endcase
   end

   // set and clear with zero source leave the csr alone
   assign csr_we = csr_i.valid && (csr_i.op[1:0] == 2'b01 || csr_i.wdata != '0);

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         mstatus         <= 64'd1 << MSTATUS_MIE;   // interrupts on
         mtvec           <= {24'b0, RESET_PC};
         mepc            <= '0;
         mcause          <= '0;
         interrupt_ack_o <= 1'b0;
      end else begin
         interrupt_ack_o <= irq_take_o;   // same edge as the jump to mtvec
         if (irq_take_o) begin
            mepc                  <= {24'b0, ir_pc_i};   // ir squashed, rerun after mret
            mcause                <= CAUSE_MEXT;
            mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
            mstatus[MSTATUS_MIE]  <= 1'b0;
         end else if (mret_i) begin
            mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
            mstatus[MSTATUS_MPIE] <= 1'b1;
         end else if (csr_we) begin
            case (csr_i.addr)
               CSR_MSTATUS: mstatus <= csr_new;
               CSR_MTVEC:   mtvec   <= csr_new;
               CSR_MEPC:    mepc    <= csr_new;
               CSR_MCAUSE:  mcause  <= csr_new;
               default: ;   // unknown csr, write dropped
            endcase
         end
      end
   end

endmodule

// File: execute/rv_execute.sv
`timescale 1ns/100ps

module rv_execute
   import rv_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  inst_t     ir_i,
   input  pc_t       pc_i,             // address of ir_i
   input  xlen_t     rs1_i,
   input  xlen_t     rs2_i,
   output rf_write_t rf_wr_o,
   output redirect_t redirect_o,
   output logic      stall_o,
   output bus_req_t  bus_o,
   input  logic      bus_read_done_i,
   input  logic      bus_write_done_i,
   input  xlen_t     bus_read_data_i,
   output csr_req_t  csr_o,
   input  xlen_t     csr_rdata_i,
   output logic      mret_o,
   output logic      irq_ok_o,         // ir may be squashed for an interrupt
   input  logic      irq_take_i,
   input  pc_t       trap_target_i
);

   opcode_e    opcode;
   funct3_t    f3;
   logic       is_load, is_store, mem_done;
   mem_state_e mem_state;
   logic       bubble_q;   // ir is the flush NOP
   xlen_t      alu_result, load_val, st_data;
   logic       taken;
   pc_t        alu_target;
   paddr_t     mem_addr;
   logic       rd_en_q, wr_en_q;
   paddr_t     addr_q;
   xlen_t      wdata_q;
   funct3_t    ls_q;

   rv_alu i_rv_alu (
      .ir_i           (ir_i),
      .pc_i           (pc_i),
      .rs1_i          (rs1_i),
      .rs2_i          (rs2_i),
      .result_o       (alu_result),
      .branch_taken_o (taken),
      .target_o       (alu_target),
      .mem_addr_o     (mem_addr)
   );

   assign opcode   = opcode_e'(ir_i[6:0]);
   assign f3       = ir_i[14:12];
   assign is_load  = opcode == OPC_LOAD;
   assign is_store = opcode == OPC_STORE;
   assign mem_done = mem_state == MEM_WAIT && (is_load ? bus_read_done_i : bus_write_done_i);
   assign stall_o  = (is_load || is_store) && !mem_done;   // hold ir until done

   // no interrupt in a bubble, mid access or on mret itself
   assign irq_ok_o = !bubble_q && !is_load && !is_store && ir_i != INST_MRET;

   always_comb begin
      case (f3)
         3'b000:  load_val = {{56{bus_read_data_i[7]}}, bus_read_data_i[7:0]};
         3'b100:  load_val = {56'b0, bus_read_data_i[7:0]};
         3'b001:  load_val = {{48{bus_read_data_i[15]}}, bus_read_data_i[15:0]};
         3'b101:  load_val = {48'b0, bus_read_data_i[15:0]};
         3'b010:  load_val = {{32{bus_read_data_i[31]}}, bus_read_data_i[31:0]};
         3'b110:  load_val = {32'b0, bus_read_data_i[31:0]};
         default: load_val = bus_read_data_i;   // ld
      endcase
   end

   always_comb begin
      case (f3[1:0])
         2'b00:   st_data = {56'b0, rs2_i[7:0]};
         2'b01:   st_data = {48'b0, rs2_i[15:0]};
         2'b10:   st_data = {32'b0, rs2_i[31:0]};
         default: st_data = rs2_i;
      endcase
   end

   // load/store step machine
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         mem_state <= MEM_IDLE;
         rd_en_q   <= 1'b0;
         wr_en_q   <= 1'b0;
      end else begin
         rd_en_q <= 1'b0;   // enables are single pulses
         wr_en_q <= 1'b0;
         case (mem_state)
            MEM_IDLE: if (is_load || is_store) begin
               rd_en_q   <= is_load;
               wr_en_q   <= is_store;
               mem_state <= MEM_WAIT;
            end
            default: if (mem_done) mem_state <= MEM_IDLE;
         endcase
      end
   end

   // address and data hold until the next access
   always_ff @(posedge clk) begin
      if (mem_state == MEM_IDLE && (is_load || is_store)) begin
         addr_q  <= mem_addr;
         wdata_q <= st_data;
         ls_q    <= f3;
      end
   end

   assign bus_o = '{address: addr_q, write_data: wdata_q, write_enable: wr_en_q,
                    read_enable: rd_en_q, ls_type: ls_q};

   // csr port, squashed with ir on an interrupt
   assign csr_o.op    = f3;
   assign csr_o.addr  = ir_i[31:20];
   assign csr_o.wdata = f3[2] ? {59'b0, ir_i[19:15]} : rs1_i;   // zimm forms
   assign csr_o.valid = opcode == OPC_SYSTEM && f3 != 3'b000 && !irq_take_i;
   assign mret_o      = ir_i == INST_MRET && !irq_take_i;

   // register write source
   always_comb begin
      rf_wr_o.idx  = ir_i[11:7];
      rf_wr_o.en   = 1'b0;
      rf_wr_o.data = alu_result;
      case (opcode)
         OPC_LUI, OPC_AUIPC, OPC_OP_IMM, OPC_OP_IMM_32,
         OPC_OP, OPC_OP_32, OPC_JAL, OPC_JALR: rf_wr_o.en = !irq_take_i;
         OPC_LOAD: begin
            rf_wr_o.en   = mem_done;
            rf_wr_o.data = load_val;
         end
         OPC_SYSTEM: begin
            rf_wr_o.en   = csr_o.valid;
            rf_wr_o.data = csr_rdata_i;   // old csr value
         end
         default: ;
      endcase
   end

   // redirect merge, interrupt first
   always_comb begin
      redirect_o.valid  = irq_take_i || mret_o || taken;
      redirect_o.target = (irq_take_i || mret_o) ? trap_target_i : alu_target;
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         bubble_q <= 1'b1;   // ir is NOP out of reset
      end else begin
         bubble_q <= redirect_o.valid;
      end
   end

   a_one_enable: assert property (@(posedge clk) disable iff (!reset)
      !(bus_o.read_enable && bus_o.write_enable));

endmodule

// File: execute/rv_alu.sv
`timescale 1ns/100ps

module rv_alu
   import rv_pkg::*;
(
   input  inst_t  ir_i,
   input  pc_t    pc_i,             // address of ir_i
   input  xlen_t  rs1_i,
   input  xlen_t  rs2_i,
   output xlen_t  result_o,
   output logic   branch_taken_o,   // also set for jal / jalr
   output pc_t    target_o,
   output paddr_t mem_addr_o
);

   opcode_e     opcode;
   funct3_t     f3;
   logic        is_reg;   // OP / OP_32, second operand from rs2
   logic        alt;      // ir[30], sub and arithmetic shift
   xlen_t       imm_u, imm_i, imm_s, imm_j, imm_b;
   xlen_t       opb;
   logic [5:0]  shamt;
   xlen_t       pc_ext;
   xlen_t       ea;       // rs1 + imm, loads/stores/jalr
   xlen_t       sra_res;  // sra / srai
   logic [31:0] sraw_res; // sraw / sraiw
   xlen_t       full_res;
   logic [31:0] word_res;
   logic        cond;

   assign opcode = opcode_e'(ir_i[6:0]);
   assign f3     = ir_i[14:12];
   assign is_reg = opcode == OPC_OP || opcode == OPC_OP_32;
   assign alt    = ir_i[30];

   // immediates
   assign imm_u = {{32{ir_i[31]}}, ir_i[31:12], 12'b0};
   assign imm_i = {{52{ir_i[31]}}, ir_i[31:20]};
   assign imm_s = {{52{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
   assign imm_j = {{44{ir_i[31]}}, ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
   assign imm_b = {{52{ir_i[31]}}, ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};

   assign opb    = is_reg ? rs2_i : imm_i;
   assign shamt  = is_reg ? rs2_i[5:0] : ir_i[25:20];
   assign pc_ext = {24'b0, pc_i};
   assign ea     = rs1_i + ((opcode == OPC_STORE) ? imm_s : imm_i);

   // sign bit shifted in
   assign sra_res  = $signed(rs1_i) >>> shamt;
   assign sraw_res = $signed(rs1_i[31:0]) >>> shamt[4:0];

   always_comb begin
      case (f3)
         3'b000:  full_res = (is_reg && alt) ? rs1_i - opb : rs1_i + opb;
         3'b001:  full_res = rs1_i << shamt;
         3'b010:  full_res = {63'b0, $signed(rs1_i) < $signed(opb)};
         3'b011:  full_res = {63'b0, rs1_i < opb};
         3'b100:  full_res = rs1_i ^ opb;
         3'b101:  full_res = alt ? sra_res : rs1_i >> shamt;
         3'b110:  full_res = rs1_i | opb;
         default: full_res = rs1_i & opb;
      endcase
   end

   // word forms, 5 bit shift amount
   always_comb begin
      case (f3)
         3'b001:  word_res = rs1_i[31:0] << shamt[4:0];
         3'b101:  word_res = alt ? sraw_res : rs1_i[31:0] >> shamt[4:0];
         default: word_res = (is_reg && alt) ? rs1_i[31:0] - opb[31:0]
                                             : rs1_i[31:0] + opb[31:0];
      endcase
   end

   always_comb begin
      case (opcode)
         OPC_LUI:                  result_o = imm_u;
         OPC_AUIPC:                result_o = pc_ext + imm_u;
         OPC_JAL, OPC_JALR:        result_o = pc_ext + 64'd4;   // link
         OPC_OP_IMM_32, OPC_OP_32: result_o = {{32{word_res[31]}}, word_res};
         default:                  result_o = full_res;
      endcase
   end

   always_comb begin
      case (f3)
         3'b000:  cond = rs1_i == rs2_i;
         3'b001:  cond = rs1_i != rs2_i;
         3'b100:  cond = $signed(rs1_i) < $signed(rs2_i);
         3'b101:  cond = $signed(rs1_i) >= $signed(rs2_i);
         3'b110:  cond = rs1_i < rs2_i;
         3'b111:  cond = rs1_i >= rs2_i;
         default: cond = 1'b0;
      endcase
   end

   assign branch_taken_o = (opcode == OPC_BRANCH && cond) ||
                           opcode == OPC_JAL || opcode == OPC_JALR;

   always_comb begin
      case (opcode)
         OPC_JAL:  target_o = pc_i + imm_j[39:0];
         OPC_JALR: target_o = ea[39:0] & ~40'd1;
         default:  target_o = pc_i + imm_b[39:0];
      endcase
   end

   assign mem_addr_o = ea[38:0];

endmodule

// File: rtl/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile
   import rv_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  reg_idx_t  rs1_idx_i,
   input  reg_idx_t  rs2_idx_i,
   output xlen_t     rs1_o,
   output xlen_t     rs2_o,
   input  rf_write_t wr_i
);

   xlen_t regs [32];

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_i.en && wr_i.idx != '0) begin   // x0 never written
         regs[wr_i.idx] <= wr_i.data;
      end
   end

   // async read ports
   assign rs1_o = regs[rs1_idx_i];
   assign rs2_o = regs[rs2_idx_i];

   a_x0_zero: assert property (@(posedge clk) disable iff (!reset)
      rs1_idx_i == '0 |-> rs1_o == '0);

endmodule

// File: rtl/rv_fetch.sv
`timescale 1ns/100ps

module rv_fetch
   import rv_pkg::*;
#(
   parameter pc_t RESET_PC = 40'h80000000
) (
   input  logic      clk,
   input  logic      reset,
   input  redirect_t redirect_i,
   input  logic      stall_i,
   output pc_t       pc_o,
   output inst_t     ir_o,
   input  inst_t     instruction_i   // word at pc_o, same cycle
);

   pc_t   pc_q;
   inst_t ir_q;
   logic  flush_q;   // ir_q holds a wrong-path word

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         pc_q    <= RESET_PC;
         ir_q    <= INST_NOP;
         flush_q <= 1'b0;
      end else if (redirect_i.valid) begin
         pc_q    <= redirect_i.target;
         ir_q    <= instruction_i;   // fall-through word, masked below
         flush_q <= 1'b1;
      end else if (!stall_i) begin
         pc_q    <= pc_q + 40'd4;
         ir_q    <= instruction_i;
         flush_q <= 1'b0;
      end
      // stall holds pc and ir
   end

   assign pc_o = pc_q;
   assign ir_o = flush_q ? INST_NOP : ir_q;   // one bubble per redirect

   // jump, branch, mtvec and mepc targets all land on word boundaries
   a_target_aligned: assert property (@(posedge clk) disable iff (!reset)
      redirect_i.valid |-> redirect_i.target[1:0] == 2'b00);

endmodule

// File: common/rv_pkg.sv
package rv_pkg;

   // widths with a meaning
   typedef logic [63:0] xlen_t;     // register value
   typedef logic [31:0] inst_t;
   typedef logic [39:0] pc_t;
   typedef logic [38:0] paddr_t;    // Sv39 sized bus address
   typedef logic [4:0]  reg_idx_t;
   typedef logic [11:0] csr_addr_t;
   typedef logic [2:0]  funct3_t;   // also the load/store size code

   // major opcodes, ir[6:0]
   typedef enum logic [6:0] {
      OPC_LUI       = 7'b0110111,
      OPC_AUIPC     = 7'b0010111,
      OPC_LOAD      = 7'b0000011,
      OPC_STORE     = 7'b0100011,
      OPC_OP_IMM    = 7'b0010011,
      OPC_OP_IMM_32 = 7'b0011011,
      OPC_OP        = 7'b0110011,
      OPC_OP_32     = 7'b0111011,
      OPC_JAL       = 7'b1101111,
      OPC_JALR      = 7'b1100111,
      OPC_BRANCH    = 7'b1100011,
      OPC_SYSTEM    = 7'b1110011
   } opcode_e;

   typedef enum logic {
      MEM_IDLE,
      MEM_WAIT   // request out, waiting for done strobe
   } mem_state_e;

   // machine csrs kept
   localparam csr_addr_t CSR_MSTATUS = 12'h300;
   localparam csr_addr_t CSR_MTVEC   = 12'h305;
   localparam csr_addr_t CSR_MEPC    = 12'h341;
   localparam csr_addr_t CSR_MCAUSE  = 12'h342;

   localparam int MSTATUS_MIE  = 3;
   localparam int MSTATUS_MPIE = 7;

   localparam xlen_t CAUSE_MEXT = 64'h8000_0000_0000_000B; // interrupt bit + machine external
   localparam inst_t INST_NOP   = 32'h0000_0013;           // addi x0, x0, 0
   localparam inst_t INST_MRET  = 32'h3020_0073;

   typedef struct packed {
      paddr_t  address;
      xlen_t   write_data;
      logic    write_enable;   // one cycle pulse
      logic    read_enable;    // one cycle pulse
      funct3_t ls_type;
   } bus_req_t;

   typedef struct packed {
      logic valid;
      pc_t  target;
   } redirect_t;

   typedef struct packed {
      logic     en;
      reg_idx_t idx;
      xlen_t    data;
   } rf_write_t;

   typedef struct packed {
      funct3_t   op;      // csrrw/s/c, bit 2 selects the zimm forms
      csr_addr_t addr;
      xlen_t     wdata;   // rs1 value or zimm
      logic      valid;
   } csr_req_t;

endpackage
